// ==== run.sh ====
#!/usr/bin/env bash
# build and run the write-back testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f src.f --top-module tb_wb_top -o sim_wb
./obj_dir/sim_wb | tee sim.log

if grep -q "Test failures found" sim.log; then
	exit 1
fi
exit 0

// ==== src.f ====
verilog/cpu_pkg.sv
verilog/instr_pkg.sv
verilog/lar_wr_if.sv
verilog/wb_ctrl.sv
verilog/ldst_latency_timer.sv
verilog/lar_file.sv
verilog/wb_top.sv
tb/wb_sva.sv
tb/tb_wb_top.sv

// ==== tb/tb_wb_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_wb_top import cpu_pkg::*, instr_pkg::*; ();

	localparam int N_ALU = 32;
	localparam int N_STALL = 24;
	localparam int N_MIX = 200;
	localparam int NUM_INSTR = N_ALU + 4 * 9 + N_STALL + N_MIX;
	localparam int CYCLE_LIMIT = NUM_INSTR * 8 + 100;

	logic clk;
	logic arst_n;
	oper_t oper;
	lar_idx_t ra_index;
	data_t computed_data;
	addr_t ldst_addr;
	logic stall;
	lar_idx_t rd_index;
	data_t rd_data;
	addr_t rd_addr;
	data_type_t rd_data_type;
	int_size_t rd_int_size;

	// reference model of the LAR entries and the backing words
	data_t m_data [NUM_LARS];
	addr_t m_addr [NUM_LARS];
	data_type_t m_dtype [NUM_LARS];
	int_size_t m_isize [NUM_LARS];
	data_t m_mem [MEM_WORDS];

	oper_t load_ops [9] = '{ld_u8, ld_s8, ld_u16, ld_s16, ld_u32, ld_s32, ld_u64, ld_s64, ld_f16};

	int seed;
	int checks;
	int errors;
	int tests_run;
	int cycle_count;

	wb_top wb_top_inst (
		.clk(clk),
		.arst_n(arst_n),
		.oper(oper),
		.ra_index(ra_index),
		.computed_data(computed_data),
		.ldst_addr(ldst_addr),
		.stall(stall),
		.rd_index(rd_index),
		.rd_data(rd_data),
		.rd_addr(rd_addr),
		.rd_data_type(rd_data_type),
		.rd_int_size(rd_int_size)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic bit is_load(input oper_t op);
		case (op)
			ld_u8, ld_s8, ld_u16, ld_s16, ld_u32, ld_s32, ld_u64, ld_s64, ld_f16:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	function automatic int_size_t expected_size(input oper_t op);
		case (op)
			ld_u8, ld_s8:
				return int_sz_8;
			ld_u16, ld_s16, ld_f16:
				return int_sz_16;
			ld_u32, ld_s32:
				return int_sz_32;
			default:
				return int_sz_64;
		endcase
	endfunction

	function automatic data_type_t expected_type(input oper_t op);
		case (op)
			ld_s8, ld_s16, ld_s32, ld_s64:
				return dt_sgn_int;
			ld_f16:
				return dt_bfloat16;
			default:
				return dt_unsgn_int;
		endcase
	endfunction

	function automatic int size_bits(input int_size_t isize);
		case (isize)
			int_sz_8:
				return 8;
			int_sz_16:
				return 16;
			int_sz_32:
				return 32;
			default:
				return 64;
		endcase
	endfunction

	function automatic data_t low_mask(input int nbits);
		if (nbits >= 64)
		begin
			return '1;
		end
		return (data_t'(1) << nbits) - data_t'(1);
	endfunction

	// zero or sign fill above the loaded width
	function automatic data_t load_value(input data_t word, input oper_t op);
		int nbits;
		data_t mask;
		data_t top;
		nbits = size_bits(expected_size(op));
		mask = low_mask(nbits);
		top = word >> (nbits - 1);
		if (expected_type(op) == dt_sgn_int && top[0])
		begin
			return word | ~mask;
		end
		return word & mask;
	endfunction

	function automatic lar_idx_t random_index();
		return lar_idx_t'($unsigned($random(seed)) % NUM_LARS);
	endfunction

	function automatic data_t random_data();
		return {$random(seed), $random(seed)};
	endfunction

	// weighted toward ALU writes and stores so loads find data
	function automatic oper_t mix_oper();
		int r;
		r = $unsigned($random(seed)) % 8;
		case (r)
			0, 1:
				return alu;
			2:
				return nop;
			3, 4:
				return st;
			default:
				return load_ops[$unsigned($random(seed)) % 9];
		endcase
	endfunction

	task automatic model_apply(input oper_t op, input lar_idx_t idx, input data_t data,
		input addr_t addr);
		logic [3:0] w;
		w = addr[6:3];
		if (op == alu)
		begin
			m_data[idx] = data;
		end
		else if (op == st)
		begin
			m_mem[w] = m_data[idx] & low_mask(size_bits(m_isize[idx]));
			m_addr[idx] = addr;
		end
		else if (is_load(op))
		begin
			m_data[idx] = load_value(m_mem[w], op);
			m_addr[idx] = addr;
			m_dtype[idx] = expected_type(op);
			m_isize[idx] = expected_size(op);
		end
	endtask

	task automatic compare_data(input string what, input data_t got, input data_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAILED at time %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic compare_addr(input string what, input addr_t got, input addr_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAILED at time %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic compare_dtype(input string what, input data_type_t got,
		input data_type_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAILED at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic compare_isize(input string what, input int_size_t got,
		input int_size_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAILED at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	// read port is combinational, sampled mid cycle
	task automatic check_entry(input lar_idx_t idx);
		rd_index = idx;
		@(negedge clk);
		compare_data($sformatf("LAR %0d data", idx), rd_data, m_data[idx]);
		compare_addr($sformatf("LAR %0d address", idx), rd_addr, m_addr[idx]);
		compare_dtype($sformatf("LAR %0d data type", idx), rd_data_type, m_dtype[idx]);
		compare_isize($sformatf("LAR %0d int size", idx), rd_int_size, m_isize[idx]);
	endtask

	task automatic check_all();
		for (int i = 0; i < NUM_LARS; i++)
		begin
			@(posedge clk);
			#1;
			check_entry(lar_idx_t'(i));
		end
	endtask

	task automatic drive_filler(input bit junk);
		if (junk)
		begin
			oper = mix_oper();
			ra_index = random_index();
			computed_data = random_data();
			ldst_addr = $random(seed);
		end
		else
		begin
			oper = nop;
		end
	endtask

	// one instruction up to the edge that makes its result visible
	task automatic run_instr(input oper_t op, input lar_idx_t idx, input data_t data,
		input addr_t addr, input bit junk);
		int waited;
		int expect_wait;
		@(posedge clk);
		#1;
		oper = op;
		ra_index = idx;
		computed_data = data;
		ldst_addr = addr;
		@(posedge clk);
		#1;
		if (op == st || is_load(op))
		begin
			checks++;
			if (!stall)
			begin
				errors++;
				$display("stall was low right after a load or store was accepted (time %0t)",
					$time);
			end
			waited = 0;
			while (stall && waited < 6)
			begin
				drive_filler(junk);
				@(posedge clk);
				#1;
				waited++;
			end
			oper = nop;
			expect_wait = MIN_LATENCY + int'(addr[1:0]);
			checks++;
			if (stall)
			begin
				errors++;
				$display("stall never dropped after a load or store (time %0t)", $time);
			end
			else if (waited != expect_wait || waited < 2 || waited > 5)
			begin
				errors++;
				$display("FAILED at time %0t: access took %0d cycles, expected %0d",
					$time, waited, expect_wait);
			end
		end
		else
		begin
			oper = nop;
		end
		@(posedge clk);
		#1;
		model_apply(op, idx, data, addr);
	endtask

	task automatic report_test(input int num, input string name, input int errs_before,
		input int checks_before);
		tests_run++;
		$display("test %0d (%s): %0d checks, %0d errors", num, name,
			checks - checks_before, errors - errs_before);
	endtask

	initial
	begin
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT)
		begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: the tests did not finish within %0d clock cycles", CYCLE_LIMIT);
		$display("Test failures found");
		$finish;
	end

	initial
	begin
		int e0;
		int c0;
		lar_idx_t e;
		lar_idx_t f;
		addr_t a;
		oper_t op;
		seed = 55;
		checks = 0;
		errors = 0;
		tests_run = 0;
		arst_n = 1'b0;
		oper = nop;
		ra_index = '0;
		computed_data = '0;
		ldst_addr = '0;
		rd_index = '0;
		for (int i = 0; i < NUM_LARS; i++)
		begin
			m_data[i] = '0;
			m_addr[i] = '0;
			m_dtype[i] = dt_unsgn_int;
			m_isize[i] = int_sz_8;
		end
		for (int j = 0; j < MEM_WORDS; j++)
		begin
			m_mem[j] = '0;
		end
		repeat (4) @(posedge clk);
		#1;
		arst_n = 1'b1;

		e0 = errors;
		c0 = checks;
		checks++;
		if (stall)
		begin
			errors++;
			$display("stall is high after reset");
		end
		check_all();
		report_test(1, "reset values", e0, c0);

		e0 = errors;
		c0 = checks;
		for (int n = 0; n < N_ALU; n++)
		begin
			e = random_index();
			run_instr(alu, e, random_data(), $random(seed), 1'b0);
			check_entry(e);
		end
		check_all();
		report_test(2, "ALU writes", e0, c0);

		// widen the entry first so the store keeps all 64 bits
		e0 = errors;
		c0 = checks;
		for (int k = 0; k < 9; k++)
		begin
			e = random_index();
			f = random_index();
			a = $random(seed);
			run_instr(ld_u64, e, '0, $random(seed), 1'b0);
			run_instr(alu, e, random_data(), a, 1'b0);
			run_instr(st, e, '0, a, 1'b0);
			check_entry(e);
			run_instr(load_ops[k], f, '0, a, 1'b0);
			check_entry(f);
		end
		check_all();
		report_test(3, "store then load", e0, c0);

		// random instructions presented while stalled
		e0 = errors;
		c0 = checks;
		for (int n = 0; n < N_STALL; n++)
		begin
			e = random_index();
			if (n % 2 == 0)
			begin
				op = st;
			end
			else
			begin
				op = load_ops[$unsigned($random(seed)) % 9];
			end
			run_instr(op, e, random_data(), $random(seed), 1'b1);
			check_entry(e);
		end
		check_all();
		report_test(4, "stall and latency", e0, c0);

		e0 = errors;
		c0 = checks;
		for (int n = 0; n < N_MIX; n++)
		begin
			e = random_index();
			run_instr(mix_oper(), e, random_data(), $random(seed), 1'b0);
			check_entry(e);
		end
		check_all();
		report_test(5, "random mix", e0, c0);

		$display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
		if (errors == 0)
		begin
			$display("All tests passed!");
		end
		else
		begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/wb_sva.sv ====
`timescale 1ns/100ps
`default_nettype none

module wb_sva (
	input wire clk,
	input wire arst_n,
	input wire stall,
	input wire req,
	input wire valid,
	input wire in_wait
);

	// first cycle out of reset sees a no-op
	ast_stall_low_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> !stall)
		else $error("stall high in the first cycle after reset");

	// an accepted load or store issues its request at the next edge
	ast_ldst_issues_req: assert property (@(posedge clk) disable iff (!arst_n)
		stall && !in_wait |=> req)
		else $error("load or store accepted without a request");

	ast_stall_enters_wait: assert property (@(posedge clk) disable iff (!arst_n)
		stall && !in_wait |=> in_wait)
		else $error("stall raised without entering the wait state");

	// stall only drops in the cycle that valid arrives
	ast_stall_until_valid: assert property (@(posedge clk) disable iff (!arst_n)
		stall && !valid |=> stall || valid)
		else $error("stall dropped before valid");

	// request lasts one cycle since the wait state follows it
	ast_no_req_while_waiting: assert property (@(posedge clk) disable iff (!arst_n)
		in_wait |=> !req)
		else $error("request issued from the wait state");

endmodule

bind wb_ctrl wb_sva wb_sva_inst (
	.clk(clk),
	.arst_n(arst_n),
	.stall(stall),
	.req(wr.req),
	.valid(wr.valid),
	.in_wait(state == wait_valid)
);

`default_nettype wire

// ==== verilog/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	// datapath widths
	localparam int DATA_W = 64;
	localparam int ADDR_W = 32;

	// LAR file and backing store sizes
	localparam int NUM_LARS = 8;
	localparam int LAR_IDX_W = 3;
	localparam int MEM_WORDS = 16;
	localparam int MEM_IDX_W = $clog2(MEM_WORDS);

	// base memory delay, address bits 1:0 add up to three more cycles
	localparam int MIN_LATENCY = 2;

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [LAR_IDX_W-1:0] lar_idx_t;

	typedef enum logic [1:0]
	{
		dt_unsgn_int,
		dt_sgn_int,
		dt_bfloat16
	} data_type_t;

	typedef enum logic [1:0]
	{
		int_sz_8,
		int_sz_16,
		int_sz_32,
		int_sz_64
	} int_size_t;

endpackage

`default_nettype wire

// ==== verilog/instr_pkg.sv ====
`default_nettype none

package instr_pkg;

	// decoded operations, loads kept contiguous
	typedef enum logic [3:0]
	{
		alu,
		nop,
		ld_u8,
		ld_s8,
		ld_u16,
		ld_s16,
		ld_u32,
		ld_s32,
		ld_u64,
		ld_s64,
		ld_f16,
		st
	} oper_t;

	typedef logic [1:0] group_t;

	localparam group_t GROUP_ALU = 2'd0;
	localparam group_t GROUP_NOP = 2'd1;
	localparam group_t GROUP_LD = 2'd2;
	localparam group_t GROUP_ST = 2'd3;

	typedef enum logic [1:0]
	{
		wr_only_data,
		wr_ld,
		wr_st
	} write_type_t;

	function automatic group_t oper_group(input oper_t op);
		group_t grp;
		case (op)
			alu:
				grp = GROUP_ALU;
			ld_u8, ld_s8, ld_u16, ld_s16, ld_u32, ld_s32, ld_u64, ld_s64, ld_f16:
				grp = GROUP_LD;
			st:
				grp = GROUP_ST;
			// unused encodings behave as no-ops
			default:
				grp = GROUP_NOP;
		endcase
		return grp;
	endfunction

endpackage

`default_nettype wire

// ==== verilog/lar_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module lar_file import cpu_pkg::*, instr_pkg::*; (
	input wire clk,
	input wire arst_n,
	lar_wr_if.lar_file wr,
	input wire lar_idx_t rd_index,
	output data_t rd_data,
	output addr_t rd_addr,
	output data_type_t rd_data_type,
	output int_size_t rd_int_size,
	output logic tmr_start,
	output logic [1:0] tmr_latency,
	input wire tmr_done
);

	data_t lar_data [NUM_LARS];
	addr_t lar_addr [NUM_LARS];
	data_type_t lar_dtype [NUM_LARS];
	int_size_t lar_isize [NUM_LARS];
	data_t mem [MEM_WORDS];

	// pending load or store
	write_type_t pend_type;
	lar_idx_t pend_index;
	addr_t pend_addr;
	data_type_t pend_dtype;
	int_size_t pend_isize;
	logic [MEM_IDX_W-1:0] pend_word;
	logic ldst_req;

	// low bytes of a word, sign filled only for signed ints
	function automatic data_t size_extend(input data_t word, input data_type_t dtype,
		input int_size_t isize);
		logic sgn;
		data_t res;
		sgn = (dtype == dt_sgn_int);
		case (isize)
			int_sz_8:
				res = {{56{sgn & word[7]}}, word[7:0]};
			int_sz_16:
				res = {{48{sgn & word[15]}}, word[15:0]};
			int_sz_32:
				res = {{32{sgn & word[31]}}, word[31:0]};
			default:
				res = word;
		endcase
		return res;
	endfunction

	assign ldst_req = wr.req && (wr.write_type != wr_only_data);
	assign tmr_start = ldst_req;
	assign tmr_latency = wr.ldst_addr[1:0];
	assign pend_word = pend_addr[MEM_IDX_W+2:3];

	// completion coincides with the timer's last cycle
	assign wr.valid = tmr_done;

	always_ff @(posedge clk)
	begin
		if (ldst_req)
		begin
			pend_type <= wr.write_type;
			pend_index <= wr.index;
			pend_addr <= wr.ldst_addr;
			pend_dtype <= wr.data_type;
			pend_isize <= wr.int_size;
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < NUM_LARS; i++)
			begin
				lar_data[i] <= '0;
				lar_addr[i] <= '0;
				lar_dtype[i] <= dt_unsgn_int;
				lar_isize[i] <= int_sz_8;
			end
			for (int j = 0; j < MEM_WORDS; j++)
			begin
				mem[j] <= '0;
			end
		end
		else
		begin
			if (wr.req && (wr.write_type == wr_only_data))
			begin
				lar_data[wr.index] <= wr.non_ldst_data;
			end

			if (tmr_done && (pend_type == wr_ld))
			begin
				lar_data[pend_index] <= size_extend(mem[pend_word], pend_dtype, pend_isize);
				lar_addr[pend_index] <= pend_addr;
				lar_dtype[pend_index] <= pend_dtype;
				lar_isize[pend_index] <= pend_isize;
			end
			else if (tmr_done)
			begin
				// store cuts to the entry's own size, upper bytes cleared
				mem[pend_word] <= size_extend(lar_data[pend_index], dt_unsgn_int,
					lar_isize[pend_index]);
				lar_addr[pend_index] <= pend_addr;
			end
		end
	end

	assign rd_data = lar_data[rd_index];
	assign rd_addr = lar_addr[rd_index];
	assign rd_data_type = lar_dtype[rd_index];
	assign rd_int_size = lar_isize[rd_index];

endmodule

`default_nettype wire

// ==== verilog/lar_wr_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface lar_wr_if import cpu_pkg::*, instr_pkg::*; ();

	logic req;
	write_type_t write_type;
	lar_idx_t index;
	data_t non_ldst_data;
	addr_t ldst_addr;
	data_type_t data_type;
	int_size_t int_size;
	// one-cycle completion of a load or store
	logic valid;

	modport ctrl
	(
		output req,
		output write_type,
		output index,
		output non_ldst_data,
		output ldst_addr,
		output data_type,
		output int_size,
		input valid
	);

	modport lar_file
	(
		input req,
		input write_type,
		input index,
		input non_ldst_data,
		input ldst_addr,
		input data_type,
		input int_size,
		output valid
	);

endinterface

`default_nettype wire

// ==== verilog/ldst_latency_timer.sv ====
`timescale 1ns/100ps
`default_nettype none

module ldst_latency_timer import cpu_pkg::*; (
	input wire clk,
	input wire arst_n,
	input wire start,
	input wire [1:0] latency,
	output logic done
);

	// holds up to MIN_LATENCY + 3
	logic [2:0] count;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			count <= 3'd0;
		end
		else if (start)
		begin
			// extra wait states on top of the base delay
			count <= 3'(MIN_LATENCY) + {1'b0, latency};
		end
		else if (count != 3'd0)
		begin
			count <= count - 3'd1;
		end
	end

	// last cycle of the access, zero means idle
	assign done = (count == 3'd1);

endmodule

`default_nettype wire

// ==== verilog/wb_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module wb_ctrl import cpu_pkg::*, instr_pkg::*; (
	input wire clk,
	input wire arst_n,
	input wire oper_t oper,
	input wire lar_idx_t ra_index,
	input wire data_t computed_data,
	input wire addr_t ldst_addr,
	output logic stall,
	lar_wr_if.ctrl wr
);

	typedef enum logic
	{
		regular,
		wait_valid
	} state_t;

	state_t state;
	state_t next_state;
	group_t group;
	logic is_ldst;
	logic accept;
	data_type_t dec_data_type;
	int_size_t dec_int_size;

	assign group = oper_group(oper);
	assign is_ldst = (group == GROUP_LD) || (group == GROUP_ST);

	// no-ops never reach the LAR file
	assign accept = (state == regular) && (group != GROUP_NOP);

	always_comb
	begin
		case (state)
			regular:
				next_state = is_ldst ? wait_valid : regular;
			wait_valid:
				next_state = wr.valid ? regular : wait_valid;
			default:
				next_state = regular;
		endcase
	end

	// front end held for the whole memory access
	assign stall = (next_state != regular);

	// loads pair up unsigned and signed variants per size
	always_comb
	begin
		case (oper)
			ld_u8, ld_s8:
				dec_int_size = int_sz_8;
			ld_u16, ld_s16:
				dec_int_size = int_sz_16;
			ld_u32, ld_s32:
				dec_int_size = int_sz_32;
			// bfloat16 is tagged with size 16 as well
			ld_f16:
				dec_int_size = int_sz_16;
			default:
				dec_int_size = int_sz_64;
		endcase

		case (oper)
			ld_s8, ld_s16, ld_s32, ld_s64:
				dec_data_type = dt_sgn_int;
			ld_f16:
				dec_data_type = dt_bfloat16;
			default:
				dec_data_type = dt_unsgn_int;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= regular;
			wr.req <= 1'b0;
		end
		else
		begin
			state <= next_state;
			wr.req <= accept;
		end
	end

	// request payload, only meaningful while req is high
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			wr.index <= ra_index;
			wr.non_ldst_data <= computed_data;
			wr.ldst_addr <= ldst_addr;
			wr.data_type <= dec_data_type;
			wr.int_size <= dec_int_size;
			case (group)
				GROUP_LD:
					wr.write_type <= wr_ld;
				GROUP_ST:
					wr.write_type <= wr_st;
				default:
					wr.write_type <= wr_only_data;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/wb_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module wb_top import cpu_pkg::*, instr_pkg::*; (
	input wire clk,
	input wire arst_n,
	input wire oper_t oper,
	input wire lar_idx_t ra_index,
	input wire data_t computed_data,
	input wire addr_t ldst_addr,
	output logic stall,
	input wire lar_idx_t rd_index,
	output data_t rd_data,
	output addr_t rd_addr,
	output data_type_t rd_data_type,
	output int_size_t rd_int_size
);

	logic tmr_start;
	logic [1:0] tmr_latency;
	logic tmr_done;

	lar_wr_if wr_bus ();

	wb_ctrl wb_ctrl_inst (
		.clk(clk),
		.arst_n(arst_n),
		.oper(oper),
		.ra_index(ra_index),
		.computed_data(computed_data),
		.ldst_addr(ldst_addr),
		.stall(stall),
		.wr(wr_bus.ctrl)
	);

	lar_file lar_file_inst (
		.clk(clk),
		.arst_n(arst_n),
		.wr(wr_bus.lar_file),
		.rd_index(rd_index),
		.rd_data(rd_data),
		.rd_addr(rd_addr),
		.rd_data_type(rd_data_type),
		.rd_int_size(rd_int_size),
		.tmr_start(tmr_start),
		.tmr_latency(tmr_latency),
		.tmr_done(tmr_done)
	);

	// memory delay model for loads and stores
	ldst_latency_timer timer_inst (
		.clk(clk),
		.arst_n(arst_n),
		.start(tmr_start),
		.latency(tmr_latency),
		.done(tmr_done)
	);

endmodule

`default_nettype wire
